// ==== src/uart_pkg.sv ====
////////////////////
// Serial line format shared by the receiver, the transmitter and the top level.
// Import it inside the module body and use scoped names in port lists.
////////////////////
package uart_pkg;

  // Data bits per frame, sent LSB first.
  localparam int DATA_BITS = 8;

  // Bytes that make up one command.
  localparam int CMD_WORDS = 5;

  // Width of an assembled command.
  localparam int CMD_WIDTH = DATA_BITS * CMD_WORDS;

  // Clock cycles per bit period.
  localparam int CLK_PER_BIT = 8;

  // Longest reply in bytes.
  localparam int RESP_BYTES_MAX = 3;

endpackage

// ==== src/cmd_pkg.sv ====
////////////////////
// Command opcodes, reply codes and the register map of the command port.
// Import it inside the module body and use scoped names in port lists.
////////////////////
package cmd_pkg;

  ////////////////////
  // Opcodes.
  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_READ  = 8'h02;

  ////////////////////
  // Single-byte replies.
  localparam logic [7:0] RESP_ACK = 8'h06;
  localparam logic [7:0] RESP_NAK = 8'h15;

  ////////////////////
  // Register file.
  localparam int REG_COUNT = 8;
  localparam int REG_WIDTH = 24;

  // Byte positions inside the command word.
  localparam int OP_BYTE   = 0;
  localparam int ADDR_BYTE = 1;
  // Data starts here, LSB first.
  localparam int DATA_BYTE = 2;

endpackage

// ==== src/rx_line_cond.sv ====
////////////////////
// Synchronizes and deglitches the rx pin ahead of the receiver.
////////////////////
module rx_line_cond (
  input  logic clk_i,
  input  logic rst_in,
  input  logic rx_i,
  output logic rx_sync_o
);

  logic       sync_q1;
  logic       sync_q2;
  logic [1:0] hist_q;

  // All stages reset to the idle line level.
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      sync_q1 <= 1'b1;
      sync_q2 <= 1'b1;
      hist_q  <= 2'b11;
    end else begin
      sync_q1 <= rx_i;
      sync_q2 <= sync_q1;
      hist_q  <= {hist_q[0], sync_q2};
    end
  end

  // Two of three samples win.
  assign rx_sync_o = (sync_q2 & hist_q[0]) | (sync_q2 & hist_q[1]) | (hist_q[0] & hist_q[1]);

endmodule

// ==== src/tuart_rx.sv ====
////////////////////
// UART receiver that collects five frames into one command word.
// rdy_o pulses once per command, cmd_o holds until the next one is complete.
////////////////////
module tuart_rx (
  input  logic                         clk_i,
  input  logic                         rst_in,
  input  logic                         rx_sync_i,
  output logic [uart_pkg::CMD_WIDTH-1:0] cmd_o,
  output logic                         rdy_o
);

  import uart_pkg::*;

  localparam int SMPL_W = $clog2(CLK_PER_BIT);
  localparam int BIT_W  = $clog2(DATA_BITS);
  localparam int WORD_W = $clog2(CMD_WORDS);

  typedef enum logic [2:0] {IDLE, START, DATA, DONE, STOP, WAIT_HIGH} state_t;

  state_t               state_q;
  state_t               state_d;
  logic [SMPL_W-1:0]    smpl_q;
  logic [SMPL_W-1:0]    smpl_d;
  logic [SMPL_W-1:0]    smpl_lim;
  logic [BIT_W-1:0]     bit_q;
  logic [BIT_W-1:0]     bit_d;
  logic [WORD_W-1:0]    word_q;
  logic [WORD_W-1:0]    word_d;
  logic [CMD_WIDTH-1:0] shft_q;
  logic [CMD_WIDTH-1:0] shft_d;
  logic [CMD_WIDTH-1:0] cmd_q;
  logic                 take_smpl;
  logic                 cmd_ld;

  // Half a bit during the start check, a full bit otherwise.
  assign smpl_lim  = (state_q == START) ? SMPL_W'(CLK_PER_BIT / 2 - 1)
                                        : SMPL_W'(CLK_PER_BIT - 1);
  assign take_smpl = (smpl_q == smpl_lim);

  // Last data bit of the last byte.
  assign cmd_ld = (state_q == DATA) && take_smpl && (bit_q == BIT_W'(DATA_BITS - 1))
                  && (word_q == WORD_W'(CMD_WORDS - 1));
  assign cmd_o  = cmd_q;

  ////////////////////
  // Next state.
  always_comb begin
    state_d = state_q;
    smpl_d  = smpl_q;
    bit_d   = bit_q;
    word_d  = word_q;
    shft_d  = shft_q;
    rdy_o   = 1'b0;

    case (state_q)
      IDLE: begin
        if (!rx_sync_i) begin
          state_d = START;
          smpl_d  = '0;
        end
      end
      START: begin
        smpl_d = smpl_q + 1'b1;
        if (take_smpl) begin
          // A line that is high again at mid-bit was only noise.
          state_d = rx_sync_i ? IDLE : DATA;
          smpl_d  = '0;
          bit_d   = '0;
        end
      end
      DATA: begin
        smpl_d = smpl_q + 1'b1;
        if (take_smpl) begin
          smpl_d = '0;
          bit_d  = bit_q + 1'b1;
          shft_d = {rx_sync_i, shft_q[CMD_WIDTH-1:1]};
          if (bit_q == BIT_W'(DATA_BITS - 1)) begin
            state_d = DONE;
          end
        end
      end
      DONE: begin
        state_d = STOP;
        smpl_d  = smpl_q + 1'b1;
        if (word_q == WORD_W'(CMD_WORDS - 1)) begin
          word_d = '0;
          rdy_o  = 1'b1;
        end else begin
          word_d = word_q + 1'b1;
        end
      end
      STOP: begin
        smpl_d = smpl_q + 1'b1;
        if (take_smpl) begin
          state_d = WAIT_HIGH;
        end
      end
      WAIT_HIGH: begin
        if (rx_sync_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q <= IDLE;
      smpl_q  <= '0;
      bit_q   <= '0;
      word_q  <= '0;
      shft_q  <= '0;
    end else begin
      state_q <= state_d;
      smpl_q  <= smpl_d;
      bit_q   <= bit_d;
      word_q  <= word_d;
      shft_q  <= shft_d;
    end
  end

  // Assembled command, held until the next one is complete.
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      cmd_q <= '0;
    end else if (cmd_ld) begin
      cmd_q <= shft_d;
    end
  end

endmodule

// ==== src/cmd_exec.sv ====
////////////////////
// Executes read and write commands on eight configuration registers.
// The reply is issued one cycle after the command strobe.
////////////////////
module cmd_exec (
  input  logic                                           clk_i,
  input  logic                                           rst_in,
  input  logic [uart_pkg::CMD_WIDTH-1:0]                 cmd_i,
  input  logic                                           rdy_i,
  input  logic                                           busy_i,
  output logic [cmd_pkg::REG_WIDTH-1:0]                  resp_o,
  output logic [$clog2(uart_pkg::RESP_BYTES_MAX+1)-1:0]  resp_len_o,
  output logic                                           resp_valid_o
);

  import uart_pkg::*;
  import cmd_pkg::*;

  localparam int ADDR_W = $clog2(REG_COUNT);
  localparam int LEN_W  = $clog2(RESP_BYTES_MAX + 1);

  logic [DATA_BITS-1:0] opcode;
  logic [DATA_BITS-1:0] addr;
  logic [REG_WIDTH-1:0] wdata;
  logic [ADDR_W-1:0]    idx;
  logic                 addr_ok;
  logic                 accept;
  logic                 wr_en;
  logic [REG_WIDTH-1:0] resp_d;
  logic [LEN_W-1:0]     len_d;
  logic [REG_WIDTH-1:0] regs_q [REG_COUNT];

  assign opcode  = cmd_i[OP_BYTE*DATA_BITS +: DATA_BITS];
  assign addr    = cmd_i[ADDR_BYTE*DATA_BITS +: DATA_BITS];
  assign wdata   = cmd_i[DATA_BYTE*DATA_BITS +: REG_WIDTH];
  assign idx     = addr[ADDR_W-1:0];
  assign addr_ok = (addr < DATA_BITS'(REG_COUNT));

  // Commands that arrive during a reply are dropped.
  assign accept = rdy_i & ~busy_i;

  ////////////////////
  // Decode.
  always_comb begin
    wr_en  = 1'b0;
    resp_d = REG_WIDTH'(RESP_NAK);
    len_d  = LEN_W'(1);

    case (opcode)
      OP_WRITE: begin
        if (addr_ok) begin
          wr_en  = accept;
          resp_d = REG_WIDTH'(RESP_ACK);
        end
      end
      OP_READ: begin
        if (addr_ok) begin
          resp_d = regs_q[idx];
          len_d  = LEN_W'(RESP_BYTES_MAX);
        end
      end
      default: ;
    endcase
  end

  ////////////////////
  // Register file.
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[idx] <= wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= accept;
    end
  end

  // Reply payload, held until the next accepted command.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_o     <= resp_d;
      resp_len_o <= len_d;
    end
  end

endmodule

// ==== src/tuart_tx.sv ====
////////////////////
// UART transmitter for replies of one to three bytes, LSB first.
// busy_o covers the whole burst up to the end of the last stop bit.
////////////////////
module tuart_tx (
  input  logic                                                  clk_i,
  input  logic                                                  rst_in,
  input  logic [uart_pkg::RESP_BYTES_MAX*uart_pkg::DATA_BITS-1:0] resp_i,
  input  logic [$clog2(uart_pkg::RESP_BYTES_MAX+1)-1:0]         resp_len_i,
  input  logic                                                  resp_valid_i,
  output logic                                                  tx_o,
  output logic                                                  busy_o
);

  import uart_pkg::*;

  localparam int CLK_W  = $clog2(CLK_PER_BIT);
  localparam int BIT_W  = $clog2(DATA_BITS);
  localparam int LEN_W  = $clog2(RESP_BYTES_MAX + 1);
  localparam int SHFT_W = RESP_BYTES_MAX * DATA_BITS;

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

  state_t            state_q;
  logic [CLK_W-1:0]  clk_q;
  logic [BIT_W-1:0]  bit_q;
  logic [LEN_W-1:0]  left_q;
  logic [SHFT_W-1:0] shft_q;
  logic              bit_end;
  logic              load;
  logic              shift;

  assign bit_end = (clk_q == CLK_W'(CLK_PER_BIT - 1));
  assign load    = (state_q == IDLE) && resp_valid_i;
  assign shift   = (state_q == DATA) && bit_end;

  ////////////////////
  // Frame sequencer.
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q <= IDLE;
      clk_q   <= '0;
      bit_q   <= '0;
      left_q  <= '0;
      tx_o    <= 1'b1;
      busy_o  <= 1'b0;
    end else begin
      clk_q <= bit_end ? '0 : clk_q + 1'b1;
      case (state_q)
        IDLE: begin
          clk_q <= '0;
          if (resp_valid_i) begin
            state_q <= START;
            left_q  <= resp_len_i;
            tx_o    <= 1'b0;
            busy_o  <= 1'b1;
          end
        end
        START: begin
          if (bit_end) begin
            state_q <= DATA;
            bit_q   <= '0;
            tx_o    <= shft_q[0];
          end
        end
        DATA: begin
          if (bit_end) begin
            if (bit_q == BIT_W'(DATA_BITS - 1)) begin
              state_q <= STOP;
              tx_o    <= 1'b1;
            end else begin
              bit_q <= bit_q + 1'b1;
              tx_o  <= shft_q[1];
            end
          end
        end
        STOP: begin
          if (bit_end) begin
            if (left_q == LEN_W'(1)) begin
              state_q <= IDLE;
              busy_o  <= 1'b0;
            end else begin
              // Next byte follows without an idle gap.
              state_q <= START;
              left_q  <= left_q - 1'b1;
              tx_o    <= 1'b0;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Reply bytes, consumed from the low end.
  always_ff @(posedge clk_i) begin
    if (load) begin
      shft_q <= resp_i;
    end else if (shift) begin
      shft_q <= shft_q >> 1;
    end
  end

endmodule

// ==== src/uart_cmd_top.sv ====
////////////////////
// Serial command port of the logic-analyzer core.
// Chains line conditioner, receiver, command executor and transmitter.
////////////////////
module uart_cmd_top (
  input  logic clk_i,
  input  logic rst_in,
  input  logic rx_i,
  output logic tx_o
);

  import uart_pkg::*;

  logic                               rx_sync;
  logic [CMD_WIDTH-1:0]               cmd;
  logic                               rdy;
  logic [RESP_BYTES_MAX*DATA_BITS-1:0] resp;
  logic [$clog2(RESP_BYTES_MAX+1)-1:0] resp_len;
  logic                               resp_valid;
  logic                               busy;

  rx_line_cond i_rx_line_cond (
    .clk_i    (clk_i),
    .rst_in   (rst_in),
    .rx_i     (rx_i),
    .rx_sync_o(rx_sync)
  );

  tuart_rx i_tuart_rx (
    .clk_i    (clk_i),
    .rst_in   (rst_in),
    .rx_sync_i(rx_sync),
    .cmd_o    (cmd),
    .rdy_o    (rdy)
  );

  cmd_exec i_cmd_exec (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .cmd_i       (cmd),
    .rdy_i       (rdy),
    .busy_i      (busy),
    .resp_o      (resp),
    .resp_len_o  (resp_len),
    .resp_valid_o(resp_valid)
  );

  tuart_tx i_tuart_tx (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .resp_i      (resp),
    .resp_len_i  (resp_len),
    .resp_valid_i(resp_valid),
    .tx_o        (tx_o),
    .busy_o      (busy)
  );

endmodule

// ==== sim/uart_cmd_props.sv ====
////////////////////
// Assertions on the pipeline strobes and the tx line.
// Bound into the top level below.
////////////////////
module uart_cmd_props (
  input logic                                          clk_i,
  input logic                                          rst_in,
  input logic                                          rdy_i,
  input logic                                          resp_valid_i,
  input logic                                          busy_i,
  input logic [$clog2(uart_pkg::RESP_BYTES_MAX+1)-1:0] resp_len_i,
  input logic                                          tx_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // One command, one strobe.
  a_rdy_single: assert property (@(posedge clk_i) disable iff (!rst_in)
    rdy_i |=> !rdy_i)
    else $error("rdy high on two consecutive cycles");

  a_resp_follows: assert property (@(posedge clk_i) disable iff (!rst_in)
    (rdy_i && !busy_i) |=> resp_valid_i)
    else $error("accepted command without a reply strobe");

  // Idle line.
  a_tx_idle: assert property (@(posedge clk_i) disable iff (!rst_in)
    !busy_i |-> tx_i)
    else $error("tx low while the transmitter is idle");

  a_resp_len: assert property (@(posedge clk_i) disable iff (!rst_in)
    resp_valid_i |-> (resp_len_i == 2'd1 || resp_len_i == 2'd3))
    else $error("reply length is neither one nor three bytes");

endmodule

bind uart_cmd_top uart_cmd_props i_uart_cmd_props (
  .clk_i       (clk_i),
  .rst_in      (rst_in),
  .rdy_i       (rdy),
  .resp_valid_i(resp_valid),
  .busy_i      (busy),
  .resp_len_i  (resp_len),
  .tx_i        (tx_o)
);

// ==== sim/uart_cmd_tb.sv ====
////////////////////
// Testbench of the serial command port. Replays the golden command file
// on rx and checks each reply bit by bit on tx.
////////////////////
module uart_cmd_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;

  logic   clk_i;
  logic   rst_in;
  logic   rx_i;
  logic   tx_o;
  integer seed;

  uart_cmd_top i_uart_cmd_top (
    .clk_i (clk_i),
    .rst_in(rst_in),
    .rx_i  (rx_i),
    .tx_o  (tx_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Drive and sample point, 1 ns after the edge.
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run aborted");
  endtask

  // Start bit and data bits. The line is left high for the stop bit.
  task automatic send_frame(input logic [7:0] data);
    rx_i = 1'b0;
    tick(CLK_PER_BIT);
    for (int i = 0; i < DATA_BITS; i++) begin
      rx_i = data[i];
      tick(CLK_PER_BIT);
    end
    rx_i = 1'b1;
  endtask

  task automatic send_cmd(input logic [7:0] bytes [CMD_WORDS]);
    int gap;
    for (int w = 0; w < CMD_WORDS; w++) begin
      send_frame(bytes[w]);
      if (w < CMD_WORDS - 1) begin
        // Stop bit plus 0 to 7 idle bit times.
        gap = 1 + int'($unsigned($random(seed)) % 8);
        tick(gap * CLK_PER_BIT);
      end
    end
  endtask

  task automatic wait_fall(input int limit, output bit seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      tick(1);
      if (tx_o === 1'b0) begin
        seen = 1'b1;
      end
    end
  endtask

  // Called on the first cycle of the start bit.
  task automatic recv_byte(output logic [7:0] data);
    tick(CLK_PER_BIT / 2);
    if (tx_o !== 1'b0) begin
      abort_run("start bit on tx ended before mid-bit");
    end
    for (int i = 0; i < DATA_BITS; i++) begin
      tick(CLK_PER_BIT);
      data[i] = tx_o;
    end
    tick(CLK_PER_BIT);
    if (tx_o !== 1'b1) begin
      abort_run("stop bit missing on tx");
    end
  endtask

  task automatic recv_reply(output logic [7:0] bytes [RESP_BYTES_MAX+1], output int count);
    bit seen;
    count = 0;
    wait_fall(10 * CLK_PER_BIT, seen);
    if (!seen) begin
      abort_run("no reply start bit on tx");
    end
    while (seen && count < RESP_BYTES_MAX + 1) begin
      recv_byte(bytes[count]);
      count++;
      wait_fall(2 * CLK_PER_BIT, seen);
    end
  endtask

  initial begin
    int         fd;
    int         n;
    int         line;
    int         got_len;
    logic [7:0] cmd [CMD_WORDS];
    logic [7:0] exp [RESP_BYTES_MAX];
    logic [7:0] got [RESP_BYTES_MAX+1];
    logic [7:0] exp_len;
    seed    = 32'h0318c5a2;
    line    = 0;
    rst_in  = 1'b0;
    rx_i    = 1'b1;
    tick(3);
    rst_in = 1'b1;
    tick(2 * CLK_PER_BIT);

    fd = $fopen("sim/uart_cmd_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the golden file");
    end
    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h\n", cmd[0], cmd[1], cmd[2], cmd[3],
                cmd[4], exp_len, exp[0], exp[1], exp[2]);
    while (n == 9) begin
      line++;
      send_cmd(cmd);
      recv_reply(got, got_len);
      check_value($sformatf("reply_len line %0d", line), 32'(got_len), 32'(exp_len));
      for (int i = 0; i < got_len; i++) begin
        check_value($sformatf("tx_byte%0d line %0d", i, line), 32'(got[i]), 32'(exp[i]));
      end
      n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h\n", cmd[0], cmd[1], cmd[2], cmd[3],
                  cmd[4], exp_len, exp[0], exp[1], exp[2]);
    end
    if (!$feof(fd) || line == 0) begin
      abort_run($sformatf("golden file unreadable after %0d commands", line));
    end
    $fclose(fd);

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== sim/uart_cmd_golden.txt ====
02 00 00 00 00 3 00 00 00
02 01 00 00 00 3 00 00 00
02 02 ff ff ff 3 00 00 00
02 03 00 00 00 3 00 00 00
02 04 00 00 00 3 00 00 00
02 05 12 34 56 3 00 00 00
02 06 00 00 00 3 00 00 00
02 07 00 00 00 3 00 00 00
01 00 11 22 33 1 06 00 00
01 01 a5 5a 0f 1 06 00 00
01 02 de ad be 1 06 00 00
01 03 ef 01 80 1 06 00 00
01 04 01 02 03 1 06 00 00
01 05 ff ff ff 1 06 00 00
01 06 00 00 80 1 06 00 00
01 07 7e 81 3c 1 06 00 00
02 00 00 00 00 3 11 22 33
02 01 00 00 00 3 a5 5a 0f
02 02 00 00 00 3 de ad be
02 03 00 00 00 3 ef 01 80
02 04 00 00 00 3 01 02 03
02 05 00 00 00 3 ff ff ff
02 06 00 00 00 3 00 00 80
02 07 00 00 00 3 7e 81 3c
03 02 44 55 66 1 15 00 00
00 05 00 00 00 1 15 00 00
01 0a 44 55 66 1 15 00 00
01 ff 12 34 56 1 15 00 00
02 08 00 00 00 1 15 00 00
02 02 00 00 00 3 de ad be
02 05 00 00 00 3 ff ff ff
02 07 00 00 00 3 7e 81 3c

// ==== list.f ====
src/uart_pkg.sv
src/cmd_pkg.sv
src/rx_line_cond.sv
src/tuart_rx.sv
src/cmd_exec.sv
src/tuart_tx.sv
src/uart_cmd_top.sv
sim/uart_cmd_props.sv
sim/uart_cmd_tb.sv

// ==== Makefile ====
TOP := uart_cmd_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f list.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/100ps \
		-f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
